// File: files.f
rtl/soc_pkg.sv
rtl/bus_router.sv
rtl/mem_slave.sv
rtl/led_slave.sv
rtl/status_pager.sv
rtl/soc_top.sv
tests/tb_soc_top.sv

// File: tests/tb_soc_top.sv
module tb_soc_top
    import soc_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 8;
    localparam logic [31:0] SEED = 32'h9762b345;
    // ~550 transactions at 4 cycles and 40 presses at 8 cycles, well under this
    localparam int TIMEOUT_CYCLES = 6000;
    localparam int MEM_PAIRS      = 240;

    logic       sys_clk;
    logic       arst_n;
    logic       wr_valid;
    logic       wr_ready;
    addr_t      wr_addr;
    data_t      wr_data;
    strb_t      wr_strb;
    logic       wr_resp_valid;
    resp_t      wr_resp;
    logic       rd_valid;
    logic       rd_ready;
    addr_t      rd_addr;
    logic       rd_data_valid;
    data_t      rd_data;
    resp_t      rd_resp;
    logic       btn_up;
    logic       btn_down;
    logic [7:0] led8;
    logic [3:0] led4;

    // reference model state
    data_t  mem_model [MEM_WORDS];
    led_t   led_model;
    count_t wr_model;
    count_t rd_model;
    count_t err_model;
    page_t  page_model;

    // one entry per accepted request, oldest first
    logic   exp_we   [$];
    resp_t  exp_resp [$];
    data_t  exp_data [$];
    longint exp_time [$];

    int cycles = 0;
    int errors = 0;
    int tests_run = 0;
    int tests_bad = 0;

    soc_top dut_i (.*);

    initial begin
        sys_clk = 1'b0;
        forever #(CLK_PERIOD / 2) sys_clk = ~sys_clk;
    end

    always @(posedge sys_clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run passed %0d cycles with %0d responses still outstanding",
                     TIMEOUT_CYCLES, exp_we.size());
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // returns {resp, read data} and moves the model forward
    function automatic logic [33:0] predict(input logic we, input addr_t addr,
                                            input data_t wdata, input strb_t strb);
        region_t  region;
        mem_idx_t idx;
        data_t    rdata;
        resp_t    resp;
        region = addr[31:28];
        idx    = addr[5:2]; // 64 byte alias
        rdata  = '0;
        resp   = RESP_OKAY;
        if (we)
            wr_model++;
        else
            rd_model++;
        if (region == REGION_MEM) begin
            if (we) begin
                for (int b = 0; b < 4; b++) begin
                    if (strb[b])
                        mem_model[idx][8*b +: 8] = wdata[8*b +: 8];
                end
            end else begin
                rdata = mem_model[idx];
            end
        end else if (region == REGION_LED) begin
            if (we && strb[0])
                led_model = wdata[7:0];
            else if (!we)
                rdata = {24'h0, led_model};
        end else begin
            resp = RESP_DECERR;
            err_model++;
        end
        return {resp, rdata};
    endfunction

    function automatic led_t page_byte(input page_t page);
        case (page)
            3'd0:    return led_model;
            3'd1:    return wr_model;
            3'd2:    return rd_model;
            3'd3:    return err_model;
            3'd4:    return 8'h55;
            3'd5:    return 8'hF0;
            3'd6:    return 8'h0F;
            default: return 8'hAA;
        endcase
    endfunction

    task automatic log_expected(input logic we, input addr_t addr, input data_t wdata,
                                input strb_t strb);
        logic [33:0] exp;
        exp = predict(we, addr, wdata, strb);
        exp_we.push_back(we);
        exp_resp.push_back(exp[33:32]);
        exp_data.push_back(exp[31:0]);
        exp_time.push_back($time);
    endtask

    // enter on a falling edge, leave just after the handshake edge
    task automatic wait_accept(input logic is_wr);
        logic ready_seen;
        ready_seen = 1'b0;
        while (!ready_seen) begin
            #(CLK_PERIOD / 4);
            ready_seen = is_wr ? wr_ready : rd_ready;
            @(posedge sys_clk);
            if (!ready_seen)
                @(negedge sys_clk);
        end
    endtask

    task automatic bus_write(input addr_t addr, input data_t data, input strb_t strb);
        wr_valid = 1'b1;
        wr_addr  = addr;
        wr_data  = data;
        wr_strb  = strb;
        wait_accept(1'b1);
        log_expected(1'b1, addr, data, strb);
        @(negedge sys_clk);
        wr_valid = 1'b0;
    endtask

    task automatic bus_read(input addr_t addr);
        rd_valid = 1'b1;
        rd_addr  = addr;
        wait_accept(1'b0);
        log_expected(1'b0, addr, '0, '0);
        @(negedge sys_clk);
        rd_valid = 1'b0;
    endtask

    // both requests raised in the same cycle
    task automatic bus_write_read(input addr_t waddr, input data_t wdata, input strb_t strb,
                                  input addr_t raddr);
        wr_valid = 1'b1;
        wr_addr  = waddr;
        wr_data  = wdata;
        wr_strb  = strb;
        rd_valid = 1'b1;
        rd_addr  = raddr;
        wait_accept(1'b1);
        log_expected(1'b1, waddr, wdata, strb);
        @(negedge sys_clk);
        wr_valid = 1'b0;
        wait_accept(1'b0);
        log_expected(1'b0, raddr, '0, '0);
        @(negedge sys_clk);
        rd_valid = 1'b0;
    endtask

    task automatic press(input logic up, input logic down);
        led_t exp_led;
        btn_up   = up;
        btn_down = down;
        repeat (2) @(negedge sys_clk);
        btn_up   = 1'b0;
        btn_down = 1'b0;
        repeat (6) @(negedge sys_clk);
        if (up && !down)
            page_model = page_model + 1'b1; // 3 bits, wraps mod 8
        else if (down && !up)
            page_model = page_model - 1'b1;
        exp_led = ~page_byte(page_model);
        check_value("led4 page", led4, {1'b0, page_model});
        check_value("led8 status byte", led8, exp_led);
    endtask

    task automatic drain();
        while (exp_we.size() != 0)
            @(negedge sys_clk);
    endtask

    task automatic finish_test(input string name, input int errors_before);
        drain();
        tests_run++;
        if (errors != errors_before)
            tests_bad++;
        $display("test %0d %s: %0d errors", tests_run, name, errors - errors_before);
    endtask

    // response pulses are registered, so mid-cycle is stable
    always @(negedge sys_clk) begin
        logic   is_wr;
        resp_t  got_resp;
        longint latency;
        if (arst_n && (wr_resp_valid || rd_data_valid)) begin
            if (exp_we.size() == 0) begin
                errors++;
                $display("response pulse at %0t without an outstanding request", $time);
            end else begin
                is_wr    = exp_we.pop_front();
                got_resp = is_wr ? wr_resp : rd_resp;
                latency  = ($time - exp_time.pop_front() - CLK_PERIOD / 2) / CLK_PERIOD;
                check_value("write response pulse", wr_resp_valid, is_wr);
                check_value("read data pulse", rd_data_valid, !is_wr);
                check_value("response code", got_resp, exp_resp.pop_front());
                if (!is_wr)
                    check_value("read data", rd_data, exp_data[0]);
                void'(exp_data.pop_front());
                check_value("response latency", latency, 2);
            end
        end
    end

    initial begin
        int    errs;
        addr_t addr;
        strb_t strb;
        int    coin;
        void'($urandom(SEED));
        arst_n   = 1'b0;
        wr_valid = 1'b0;
        wr_addr  = '0;
        wr_data  = '0;
        wr_strb  = '0;
        rd_valid = 1'b0;
        rd_addr  = '0;
        btn_up   = 1'b0;
        btn_down = 1'b0;
        for (int w = 0; w < MEM_WORDS; w++)
            mem_model[w] = '0;
        led_model  = '0;
        wr_model   = '0;
        rd_model   = '0;
        err_model  = '0;
        page_model = '0;
        repeat (RESET_CYCLES) @(negedge sys_clk);
        arst_n = 1'b1;

        errs = errors;
        repeat (3) @(negedge sys_clk);
        check_value("wr_ready after reset", wr_ready, 1'b1);
        check_value("rd_ready after reset", rd_ready, 1'b1);
        check_value("led8 after reset", led8, 8'hFF);
        check_value("led4 after reset", led4, 4'h0);
        finish_test("reset state", errs);

        errs = errors;
        for (int i = 0; i < MEM_PAIRS; i++) begin
            addr = {REGION_MEM, 28'($urandom())};
            strb = 4'($urandom_range(15, 1));
            bus_write(addr, $urandom(), strb);
            if (i % 2 == 0)
                bus_read(addr ^ {4'h0, 22'($urandom()), 6'h0}); // same word, aliased
            else
                bus_read({REGION_MEM, 28'($urandom())});
        end
        finish_test("memory random access", errs);

        errs = errors;
        for (int i = 0; i < 12; i++) begin
            strb    = 4'($urandom());
            strb[0] = (i % 3 != 0); // every third write skips lane 0
            bus_write({REGION_LED, 28'($urandom())}, $urandom(), strb);
            bus_read({REGION_LED, 28'($urandom())});
        end
        finish_test("led register", errs);

        errs = errors;
        for (int rg = 1; rg < 16; rg++) begin
            if (rg != 2) begin
                bus_write({4'(rg), 28'($urandom())}, $urandom(), 4'hF);
                bus_read({4'(rg), 28'($urandom())});
            end
        end
        // unmapped traffic must leave memory and led untouched
        for (int w = 0; w < MEM_WORDS; w++)
            bus_read({REGION_MEM, 22'($urandom()), 4'(w), 2'b00});
        bus_read({REGION_LED, 28'h0});
        addr = {REGION_MEM, 28'($urandom())};
        bus_write_read(addr, $urandom(), 4'hF, addr);
        bus_write_read({REGION_LED, 28'h4}, $urandom(), 4'h1, {REGION_LED, 28'h8});
        finish_test("decode error and write priority", errs);

        errs = errors;
        for (int i = 0; i < 10; i++)
            press(1'b1, 1'b0);
        for (int i = 0; i < 14; i++)
            press(1'b0, 1'b1);
        press(1'b1, 1'b1);
        for (int i = 0; i < 15; i++) begin
            coin = $urandom_range(1, 0);
            press(coin == 1, coin == 0);
        end
        finish_test("status pages", errs);

        $display("tests run %0d, tests with errors %0d, total errors %0d",
                 tests_run, tests_bad, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: rtl/soc_top.sv
module soc_top
    import soc_pkg::*;
(
    input  logic       sys_clk,
    input  logic       arst_n,
    // write request / response
    input  logic       wr_valid,
    output logic       wr_ready,
    input  addr_t      wr_addr,
    input  data_t      wr_data,
    input  strb_t      wr_strb,
    output logic       wr_resp_valid,
    output resp_t      wr_resp,
    // read request / response
    input  logic       rd_valid,
    output logic       rd_ready,
    input  addr_t      rd_addr,
    output logic       rd_data_valid,
    output data_t      rd_data,
    output resp_t      rd_resp,
    // status display
    input  logic       btn_up,
    input  logic       btn_down,
    output logic [7:0] led8,
    output logic [3:0] led4
);

    logic   mem_sel;
    logic   led_sel;
    logic   acc_we;
    addr_t  acc_addr;
    data_t  acc_wdata;
    strb_t  acc_strb;
    data_t  mem_rdata;
    data_t  led_rdata;
    led_t   led_value;
    count_t wr_count;
    count_t rd_count;
    count_t err_count;

    bus_router u_bus_router (
        .sys_clk       (sys_clk),
        .arst_n        (arst_n),
        .wr_valid      (wr_valid),
        .wr_ready      (wr_ready),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .wr_strb       (wr_strb),
        .wr_resp_valid (wr_resp_valid),
        .wr_resp       (wr_resp),
        .rd_valid      (rd_valid),
        .rd_ready      (rd_ready),
        .rd_addr       (rd_addr),
        .rd_data_valid (rd_data_valid),
        .rd_data       (rd_data),
        .rd_resp       (rd_resp),
        .mem_sel       (mem_sel),
        .led_sel       (led_sel),
        .acc_we        (acc_we),
        .acc_addr      (acc_addr),
        .acc_wdata     (acc_wdata),
        .acc_strb      (acc_strb),
        .mem_rdata     (mem_rdata),
        .led_rdata     (led_rdata),
        .wr_count      (wr_count),
        .rd_count      (rd_count),
        .err_count     (err_count)
    );

    mem_slave u_mem_slave (
        .sys_clk   (sys_clk),
        .arst_n    (arst_n),
        .mem_sel   (mem_sel),
        .acc_we    (acc_we),
        .acc_addr  (acc_addr),
        .acc_wdata (acc_wdata),
        .acc_strb  (acc_strb),
        .mem_rdata (mem_rdata)
    );

    led_slave u_led_slave (
        .sys_clk   (sys_clk),
        .arst_n    (arst_n),
        .led_sel   (led_sel),
        .acc_we    (acc_we),
        .acc_wdata (acc_wdata),
        .acc_strb  (acc_strb),
        .led_rdata (led_rdata),
        .led_value (led_value)
    );

    status_pager u_status_pager (
        .sys_clk   (sys_clk),
        .arst_n    (arst_n),
        .btn_up    (btn_up),
        .btn_down  (btn_down),
        .led_value (led_value),
        .wr_count  (wr_count),
        .rd_count  (rd_count),
        .err_count (err_count),
        .led8      (led8),
        .led4      (led4)
    );

endmodule

// File: rtl/status_pager.sv
module status_pager
    import soc_pkg::*;
(
    input  logic       sys_clk,
    input  logic       arst_n,
    input  logic       btn_up,
    input  logic       btn_down,
    input  led_t       led_value,
    input  count_t     wr_count,
    input  count_t     rd_count,
    input  count_t     err_count,
    output logic [7:0] led8,
    output logic [3:0] led4
);

    // bit 0 up, bit 1 down
    logic [1:0] btn_meta;
    logic [1:0] btn_sync;
    logic [1:0] btn_prev;
    logic [1:0] btn_rise;
    page_t      page_q;
    led_t       sel_byte;
    logic [7:0] led8_q;

    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            btn_meta <= '0;
            btn_sync <= '0;
            btn_prev <= '0;
        end else begin
            btn_meta <= {btn_down, btn_up};
            btn_sync <= btn_meta;
            btn_prev <= btn_sync;
        end
    end

    assign btn_rise = btn_sync & ~btn_prev;

    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            page_q <= '0;
        end else begin
            case (btn_rise)
                2'b01:   page_q <= (page_q == page_t'(NUM_PAGES - 1)) ? '0 : page_q + 1'b1;
                2'b10:   page_q <= (page_q == '0) ? page_t'(NUM_PAGES - 1) : page_q - 1'b1;
                default: page_q <= page_q; // none, or both at once
            endcase
        end
    end

    always_comb begin
        case (page_q)
            3'd0:    sel_byte = led_value;
            3'd1:    sel_byte = wr_count;
            3'd2:    sel_byte = rd_count;
            3'd3:    sel_byte = err_count;
            3'd4:    sel_byte = PAT_A;
            3'd5:    sel_byte = PAT_B;
            3'd6:    sel_byte = PAT_C;
            default: sel_byte = PAT_D;
        endcase
    end

    // led bank is active low
    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            led8_q <= 8'hFF;
        end else begin
            led8_q <= ~sel_byte;
        end
    end

    assign led8 = led8_q;
    assign led4 = {1'b0, page_q};

    // page only moves after exactly one button edge
    a_page_step: assert property (@(posedge sys_clk) disable iff (!arst_n)
        (page_q != $past(page_q)) |-> $past(^btn_rise));

endmodule

// File: rtl/led_slave.sv
module led_slave
    import soc_pkg::*;
(
    input  logic  sys_clk,
    input  logic  arst_n,
    input  logic  led_sel,
    input  logic  acc_we,
    input  data_t acc_wdata,
    input  strb_t acc_strb,
    output data_t led_rdata,
    output led_t  led_value
);

    led_t led_q;
    logic lane0_wr;

    // one register, every offset of the region hits it
    assign lane0_wr = led_sel && acc_we && acc_strb[0];

    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            led_q <= '0;
        end else if (lane0_wr) begin
            led_q <= acc_wdata[7:0];
        end
    end

    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            led_rdata <= '0;
        end else if (led_sel && !acc_we) begin
            led_rdata <= data_t'(led_q); // zero extended
        end
    end

    assign led_value = led_q; // level to the status pager

endmodule

// File: rtl/mem_slave.sv
module mem_slave
    import soc_pkg::*;
(
    input  logic  sys_clk,
    input  logic  arst_n,
    input  logic  mem_sel,
    input  logic  acc_we,
    input  addr_t acc_addr,
    input  data_t acc_wdata,
    input  strb_t acc_strb,
    output data_t mem_rdata
);

    data_t    mem [MEM_WORDS];
    mem_idx_t idx;

    // only word bits decode, so the region repeats every 64 bytes
    assign idx = acc_addr[5:2];

    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int w = 0; w < MEM_WORDS; w++) begin
                mem[w] <= '0;
            end
            mem_rdata <= '0;
        end else if (mem_sel) begin
            if (acc_we) begin
                for (int b = 0; b < $bits(strb_t); b++) begin
                    if (acc_strb[b])
                        mem[idx][8*b +: 8] <= acc_wdata[8*b +: 8]; // lane merge
                end
            end else begin
                mem_rdata <= mem[idx];
            end
        end
    end

    // a write with no lanes enabled would be a silent no-op
    a_write_strb: assert property (@(posedge sys_clk) disable iff (!arst_n)
        (mem_sel && acc_we) |-> (acc_strb != '0));

endmodule

// File: rtl/bus_router.sv
module bus_router
    import soc_pkg::*;
(
    input  logic   sys_clk,
    input  logic   arst_n,
    input  logic   wr_valid,
    output logic   wr_ready,
    input  addr_t  wr_addr,
    input  data_t  wr_data,
    input  strb_t  wr_strb,
    output logic   wr_resp_valid,
    output resp_t  wr_resp,
    input  logic   rd_valid,
    output logic   rd_ready,
    input  addr_t  rd_addr,
    output logic   rd_data_valid,
    output data_t  rd_data,
    output resp_t  rd_resp,
    output logic   mem_sel,
    output logic   led_sel,
    output logic   acc_we,
    output addr_t  acc_addr,
    output data_t  acc_wdata,
    output strb_t  acc_strb,
    input  data_t  mem_rdata,
    input  data_t  led_rdata,
    output count_t wr_count,
    output count_t rd_count,
    output count_t err_count
);

    bus_state_t state;
    logic       idle_free;
    logic       wr_hs;
    logic       rd_hs;
    region_t    new_region;
    region_t    req_region;
    logic       req_we;
    addr_t      req_addr;
    data_t      req_wdata;
    strb_t      req_strb;
    resp_t      resp_q;
    data_t      rdata_q;
    data_t      sel_rdata;

    function automatic logic is_mapped(region_t r);
        return (r == REGION_MEM) || (r == REGION_LED);
    endfunction

    // no new request while a response pulse is out
    assign idle_free = (state == IDLE) && !wr_resp_valid && !rd_data_valid;
    assign wr_ready  = idle_free;
    assign rd_ready  = idle_free && !wr_valid; // write wins
    assign wr_hs     = wr_valid && wr_ready;
    assign rd_hs     = rd_valid && rd_ready;

    assign new_region = wr_hs ? wr_addr[31:28] : rd_addr[31:28];
    assign req_region = req_addr[31:28];

    assign mem_sel   = (state == ACCESS) && (req_region == REGION_MEM);
    assign led_sel   = (state == ACCESS) && (req_region == REGION_LED);
    assign acc_we    = req_we;
    assign acc_addr  = req_addr;
    assign acc_wdata = req_wdata;
    assign acc_strb  = req_strb;

    always_comb begin
        case (req_region)
            REGION_MEM: sel_rdata = mem_rdata;
            REGION_LED: sel_rdata = led_rdata;
            default:    sel_rdata = '0; // decode error reads zero
        endcase
    end

    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            state         <= IDLE;
            wr_resp_valid <= 1'b0;
            rd_data_valid <= 1'b0;
            wr_count      <= '0;
            rd_count      <= '0;
            err_count     <= '0;
        end else begin
            wr_resp_valid <= 1'b0;
            rd_data_valid <= 1'b0;
            case (state)
                IDLE:    if (wr_hs || rd_hs) state <= ACCESS;
                ACCESS:  state <= RESP;
                RESP: begin
                    state         <= IDLE;
                    wr_resp_valid <= req_we;
                    rd_data_valid <= !req_we;
                end
                default: state <= IDLE;
            endcase
            if (wr_hs) wr_count <= wr_count + count_t'(1);
            if (rd_hs) rd_count <= rd_count + count_t'(1);
            if ((wr_hs || rd_hs) && !is_mapped(new_region))
                err_count <= err_count + count_t'(1);
        end
    end

    // request latch and response data
    always_ff @(posedge sys_clk) begin
        if (wr_hs || rd_hs) begin
            req_we    <= wr_hs;
            req_addr  <= wr_hs ? wr_addr : rd_addr;
            req_wdata <= wr_data;
            req_strb  <= wr_hs ? wr_strb : '0;
        end
        if (state == RESP) begin
            resp_q  <= is_mapped(req_region) ? RESP_OKAY : RESP_DECERR;
            rdata_q <= req_we ? '0 : sel_rdata;
        end
    end

    assign wr_resp = resp_q;
    assign rd_resp = resp_q;
    assign rd_data = rdata_q;

    // strobes one-hot, only in the cycle after a handshake
    a_one_slave: assert property (@(posedge sys_clk) disable iff (!arst_n)
        (mem_sel || led_sel) |-> !(mem_sel && led_sel) && $past(wr_hs || rd_hs));

    // one pulse two cycles after the handshake, readies low through it
    a_resp_no_ready: assert property (@(posedge sys_clk) disable iff (!arst_n)
        (wr_hs || rd_hs) |=> (!wr_ready && !rd_ready) [*2]
            ##1 ((wr_resp_valid ^ rd_data_valid) && !wr_ready && !rd_ready));

endmodule

// File: rtl/soc_pkg.sv
package soc_pkg;

    // bus word types
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;
    typedef logic [1:0]  resp_t;

    typedef logic [3:0]  region_t;   // addr[31:28], 256 MB each
    typedef logic [3:0]  mem_idx_t;  // addr[5:2]

    // status side
    typedef logic [7:0]  led_t;
    typedef logic [7:0]  count_t;
    typedef logic [2:0]  page_t;

    typedef enum logic [1:0] {
        IDLE,
        ACCESS,
        RESP
    } bus_state_t;

    localparam resp_t RESP_OKAY   = 2'd0;
    localparam resp_t RESP_DECERR = 2'd3;

    // region map
    localparam region_t REGION_MEM = 4'd0; // ddr stand-in
    localparam region_t REGION_LED = 4'd2;

    localparam int MEM_WORDS = 16;
    localparam int NUM_PAGES = 8;

    // fill patterns for the upper status pages
    localparam led_t PAT_A = 8'h55;
    localparam led_t PAT_B = 8'hF0;
    localparam led_t PAT_C = 8'h0F;
    localparam led_t PAT_D = 8'hAA;

endpackage
